// File: hdl/core_pkg.sv
`default_nettype none

package core_pkg;

  // Phase of the micro-operation currently in flight
  typedef enum logic [1:0] {
    CYCLE_IDLE,
    CYCLE_REG_FETCH,
    CYCLE_REG_WRITE
  } microcode_cycle;

  // Bus sources and destinations
  typedef enum logic [4:0] {
    REG_A,
    REG_B,
    REG_TEMPA,
    REG_TEMPB,
    REG_XL,
    REG_XH,
    REG_XP,
    REG_YL,
    REG_YH,
    REG_YP,
    REG_SPL,
    REG_SPH,
    REG_PCSL,
    REG_PCSH,
    REG_PCP,
    REG_FLAGS,
    // Only valid as a source
    REG_ALU,
    REG_ALU_WITH_FLAGS,
    REG_IMML,
    REG_IMMH,
    // Data RAM through an address register
    REG_MX,
    REG_MY,
    REG_MSP,
    REG_MSP_DEC,
    REG_Mn
  } reg_type;

  typedef enum logic [2:0] {
    REG_NONE,
    REG_PC,
    REG_XHL,
    REG_YHL,
    REG_SP_INC,
    REG_SP_DEC
  } reg_inc_type;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_ADC,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_type;

  // Reset vector sits on page 1
  localparam logic [11:0] PC_RESET = 12'h100;

  localparam int MEM_ADDR_W = 12;

endpackage

`default_nettype wire

// File: hdl/uop_if.sv
`timescale 1ns/1ns
`default_nettype none

interface uop_if
  import core_pkg::*;
();

  microcode_cycle current_cycle;
  reg_type        bus_input_selector;
  reg_type        bus_output_selector;
  reg_inc_type    increment_selector;
  alu_op_type     alu_op;
  logic [7:0]     immed;

  modport seq (
    output current_cycle, bus_input_selector, bus_output_selector,
    output increment_selector, alu_op, immed
  );

  modport dp (
    input current_cycle, bus_input_selector, bus_output_selector,
    input increment_selector, alu_op, immed
  );

endinterface

`default_nettype wire

// File: hdl/mem_if.sv
`timescale 1ns/1ns
`default_nettype none

interface mem_if
  import core_pkg::*;
();

  logic                  write_en;
  logic                  read_en;
  logic [MEM_ADDR_W-1:0] addr;
  logic [3:0]            write_data;
  logic [3:0]            read_data;

  modport master (output write_en, read_en, addr, write_data, input read_data);

  modport slave (input write_en, read_en, addr, write_data, output read_data);

endinterface

`default_nettype wire

// File: hdl/uop_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module uop_sequencer
  import core_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        uop_valid,
  output logic        uop_ready,
  input  reg_type     bus_input_selector,
  input  reg_type     bus_output_selector,
  input  reg_inc_type increment_selector,
  input  alu_op_type  alu_op,
  input  logic [7:0]  immed,
  uop_if.seq          uop
);

  microcode_cycle state;

  reg_type     src_q;
  reg_type     dst_q;
  reg_inc_type inc_q;
  alu_op_type  op_q;
  logic [7:0]  immed_q;

  assign uop_ready = (state == CYCLE_IDLE);

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state <= CYCLE_IDLE;
    end else begin
      case (state)
        CYCLE_IDLE: if (uop_valid) state <= CYCLE_REG_FETCH;
        CYCLE_REG_FETCH: state <= CYCLE_REG_WRITE;
        default: state <= CYCLE_IDLE;
      endcase
    end
  end

  // Fields held until the next accept
  always_ff @(posedge clk) begin
    if (uop_valid && uop_ready) begin
      src_q   <= bus_input_selector;
      dst_q   <= bus_output_selector;
      inc_q   <= increment_selector;
      op_q    <= alu_op;
      immed_q <= immed;
    end
  end

  assign uop.current_cycle       = state;
  assign uop.bus_input_selector  = src_q;
  assign uop.bus_output_selector = dst_q;
  assign uop.increment_selector  = inc_q;
  assign uop.alu_op              = op_q;
  assign uop.immed               = immed_q;

endmodule

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu
  import core_pkg::*;
(
  input  logic [3:0] a,
  input  logic [3:0] b,
  input  logic       carry_in,
  input  alu_op_type op,
  output logic [3:0] result,
  output logic       carry_out,
  output logic       zero
);

  // Bit 4 holds carry or borrow
  logic [4:0] sum;

  always_comb begin
    sum = 5'h00;
    case (op)
      ALU_ADD: sum = {1'b0, a} + {1'b0, b};
      ALU_ADC: sum = {1'b0, a} + {1'b0, b} + {4'h0, carry_in};
      // Wraps into bit 4 when b > a
      ALU_SUB: sum = {1'b0, a} - {1'b0, b};
      ALU_AND: sum = {1'b0, a & b};
      ALU_OR:  sum = {1'b0, a | b};
      ALU_XOR: sum = {1'b0, a ^ b};
      default: sum = 5'h00;
    endcase
  end

  assign result    = sum[3:0];
  assign carry_out = sum[4];
  assign zero      = (sum[3:0] == 4'h0);

endmodule

`default_nettype wire

// File: hdl/reg_mux.sv
`timescale 1ns/1ns
`default_nettype none

module reg_mux
  import core_pkg::*;
(
  input  reg_type     selector,
  input  logic [3:0]  a,
  input  logic [3:0]  b,
  input  logic [3:0]  temp_a,
  input  logic [3:0]  temp_b,
  input  logic [3:0]  alu_result,
  input  logic [3:0]  flags,
  input  logic [3:0]  memory_read_data,
  input  logic [11:0] x,
  input  logic [11:0] y,
  input  logic [11:0] pc,
  input  logic [7:0]  sp,
  input  logic [7:0]  immed,
  output logic [3:0]  out,
  output logic        use_memory,
  output logic [11:0] memory_addr
);

  logic [7:0] sp_dec;

  assign sp_dec = sp - 8'h01;

  always_comb begin
    out         = 4'h0;
    use_memory  = 1'b0;
    memory_addr = 12'h000;
    case (selector)
      REG_A:     out = a;
      REG_B:     out = b;
      REG_TEMPA: out = temp_a;
      REG_TEMPB: out = temp_b;
      REG_XL:    out = x[3:0];
      REG_XH:    out = x[7:4];
      REG_XP:    out = x[11:8];
      REG_YL:    out = y[3:0];
      REG_YH:    out = y[7:4];
      REG_YP:    out = y[11:8];
      REG_SPL:   out = sp[3:0];
      REG_SPH:   out = sp[7:4];
      REG_PCSL:  out = pc[3:0];
      REG_PCSH:  out = pc[7:4];
      REG_PCP:   out = pc[11:8];
      REG_FLAGS: out = flags;
      REG_ALU, REG_ALU_WITH_FLAGS: out = alu_result;
      REG_IMML:  out = immed[3:0];
      REG_IMMH:  out = immed[7:4];
      default: begin
        // Memory sources all return the RAM nibble
        out        = memory_read_data;
        use_memory = 1'b1;
        case (selector)
          REG_MX:      memory_addr = x;
          REG_MY:      memory_addr = y;
          REG_MSP:     memory_addr = {4'h0, sp};
          REG_MSP_DEC: memory_addr = {4'h0, sp_dec};
          default:     memory_addr = {8'h00, immed[3:0]};
        endcase
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/regs.sv
`timescale 1ns/1ns
`default_nettype none

module regs
  import core_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  uop_if.dp           uop,
  mem_if.master       mem,
  output logic [3:0]  a,
  output logic [3:0]  b,
  output logic [3:0]  temp_a,
  output logic [3:0]  temp_b,
  output logic [11:0] x,
  output logic [11:0] y,
  output logic [11:0] pc,
  output logic [7:0]  sp,
  output logic        zero,
  output logic        carry,
  output logic        decimal,
  output logic        interrupt
);

  logic [3:0]  bus_value;
  logic        use_memory;
  logic [11:0] read_addr;
  logic [3:0]  alu_result;
  logic        alu_carry;
  logic        alu_zero;

  logic        dst_is_mem;
  logic [11:0] dst_addr;
  logic [11:0] write_addr;
  logic [7:0]  sp_dec;

  assign sp_dec = sp - 8'h01;

  reg_mux u_mux (
    .selector         (uop.bus_input_selector),
    .a                (a),
    .b                (b),
    .temp_a           (temp_a),
    .temp_b           (temp_b),
    .alu_result       (alu_result),
    .flags            ({interrupt, decimal, zero, carry}),
    .memory_read_data (mem.read_data),
    .x                (x),
    .y                (y),
    .pc               (pc),
    .sp               (sp),
    .immed            (uop.immed),
    .out              (bus_value),
    .use_memory       (use_memory),
    .memory_addr      (read_addr)
  );

  alu u_alu (
    .a         (temp_a),
    .b         (temp_b),
    .carry_in  (carry),
    .op        (uop.alu_op),
    .result    (alu_result),
    .carry_out (alu_carry),
    .zero      (alu_zero)
  );

  // Store address for a memory destination
  always_comb begin
    dst_is_mem = 1'b1;
    case (uop.bus_output_selector)
      REG_MX:      dst_addr = x;
      REG_MY:      dst_addr = y;
      REG_MSP:     dst_addr = {4'h0, sp};
      REG_MSP_DEC: dst_addr = {4'h0, sp_dec};
      REG_Mn:      dst_addr = {8'h00, uop.immed[3:0]};
      default: begin
        dst_is_mem = 1'b0;
        dst_addr   = 12'h000;
      end
    endcase
  end

  // Once the store is pending its data is already latched
  assign mem.addr    = (use_memory && !mem.write_en) ? read_addr : write_addr;
  assign mem.read_en = use_memory && (uop.current_cycle == CYCLE_REG_FETCH);

  always_ff @(posedge clk) begin
    if (uop.current_cycle == CYCLE_REG_FETCH && dst_is_mem) begin
      write_addr     <= dst_addr;
      mem.write_data <= bus_value;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      a <= 4'h0;
      b <= 4'h0;
      temp_a <= 4'h0;
      temp_b <= 4'h0;
      x <= 12'h000;
      y <= 12'h000;
      sp <= 8'h00;
      pc <= PC_RESET;
      {interrupt, decimal, zero, carry} <= 4'h0;
      mem.write_en <= 1'b0;
    end else begin
      if (uop.current_cycle == CYCLE_REG_FETCH) begin
        mem.write_en <= dst_is_mem;
        if (uop.increment_selector == REG_PC) pc <= pc + 12'h001;
      end
      if (uop.current_cycle == CYCLE_REG_WRITE) begin
        mem.write_en <= 1'b0;
        case (uop.bus_output_selector)
          REG_A:     a <= bus_value;
          REG_B:     b <= bus_value;
          REG_TEMPA: temp_a <= bus_value;
          REG_TEMPB: temp_b <= bus_value;
          REG_XL:    x[3:0] <= bus_value;
          REG_XH:    x[7:4] <= bus_value;
          REG_XP:    x[11:8] <= bus_value;
          REG_YL:    y[3:0] <= bus_value;
          REG_YH:    y[7:4] <= bus_value;
          REG_YP:    y[11:8] <= bus_value;
          REG_SPL:   sp[3:0] <= bus_value;
          REG_SPH:   sp[7:4] <= bus_value;
          REG_PCSL:  pc[3:0] <= bus_value;
          REG_PCSH:  pc[7:4] <= bus_value;
          REG_PCP:   pc[11:8] <= bus_value;
          REG_FLAGS: {interrupt, decimal, zero, carry} <= bus_value;
          default: ;
        endcase
        if (uop.bus_input_selector == REG_ALU_WITH_FLAGS &&
            uop.bus_output_selector != REG_FLAGS) begin
          zero  <= alu_zero;
          carry <= alu_carry;
        end
        // Later assignment so the increment beats a bus write
        case (uop.increment_selector)
          REG_XHL:    x[7:0] <= x[7:0] + 8'h01;
          REG_YHL:    y[7:0] <= y[7:0] + 8'h01;
          REG_SP_INC: sp <= sp + 8'h01;
          REG_SP_DEC: sp <= sp_dec;
          default: ;
        endcase
      end
    end
  end

  a_write_window: assert property (@(posedge clk) disable iff (!reset_n)
    mem.write_en |-> uop.current_cycle == CYCLE_REG_WRITE ##1 !mem.write_en);

  // A load never shares its cycle with a pending store
  a_read_window: assert property (@(posedge clk) disable iff (!reset_n)
    mem.read_en |-> !mem.write_en);

endmodule

`default_nettype wire

// File: hdl/data_ram.sv
`timescale 1ns/1ns
`default_nettype none

module data_ram
  import core_pkg::*;
(
  input logic  clk,
  mem_if.slave mem
);

  logic [3:0] ram [0:(1 << MEM_ADDR_W) - 1];

  assign mem.read_data = ram[mem.addr];

  always_ff @(posedge clk) begin
    if (mem.write_en) ram[mem.addr] <= mem.write_data;
  end

  // Store address comes from a register latched one cycle earlier
  a_addr_known: assert property (@(posedge clk)
    mem.write_en |-> !$isunknown(mem.addr));

endmodule

`default_nettype wire

// File: hdl/core_top.sv
`timescale 1ns/1ns
`default_nettype none

module core_top
  import core_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        uop_valid,
  output logic        uop_ready,
  input  reg_type     bus_input_selector,
  input  reg_type     bus_output_selector,
  input  reg_inc_type increment_selector,
  input  alu_op_type  alu_op,
  input  logic [7:0]  immed,
  output logic [3:0]  a,
  output logic [3:0]  b,
  output logic [3:0]  temp_a,
  output logic [3:0]  temp_b,
  output logic [11:0] x,
  output logic [11:0] y,
  output logic [11:0] pc,
  output logic [7:0]  sp,
  output logic        zero,
  output logic        carry,
  output logic        decimal,
  output logic        interrupt
);

  uop_if uop_bus ();
  mem_if mem_bus ();

  uop_sequencer u_seq (
    .clk                 (clk),
    .reset_n             (reset_n),
    .uop_valid           (uop_valid),
    .uop_ready           (uop_ready),
    .bus_input_selector  (bus_input_selector),
    .bus_output_selector (bus_output_selector),
    .increment_selector  (increment_selector),
    .alu_op              (alu_op),
    .immed               (immed),
    .uop                 (uop_bus.seq)
  );

  regs u_regs (
    .clk       (clk),
    .reset_n   (reset_n),
    .uop       (uop_bus.dp),
    .mem       (mem_bus.master),
    .a         (a),
    .b         (b),
    .temp_a    (temp_a),
    .temp_b    (temp_b),
    .x         (x),
    .y         (y),
    .pc        (pc),
    .sp        (sp),
    .zero      (zero),
    .carry     (carry),
    .decimal   (decimal),
    .interrupt (interrupt)
  );

  data_ram u_ram (
    .clk (clk),
    .mem (mem_bus.slave)
  );

endmodule

`default_nettype wire

// File: verification/core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module core_tb
  import core_pkg::*;
();

  localparam int NUM_UOPS = 400;
  // Reset, worst-case micro-op plus gap, margin
  localparam int TIMEOUT_CYCLES = 10 + NUM_UOPS * 7 + 100;

  typedef struct packed {
    logic [3:0]  a;
    logic [3:0]  b;
    logic [3:0]  temp_a;
    logic [3:0]  temp_b;
    logic [11:0] x;
    logic [11:0] y;
    logic [11:0] pc;
    logic [7:0]  sp;
    logic [3:0]  flags;
  } model_t;

  logic        clk = 1'b0;
  logic        reset_n;
  logic        uop_valid;
  logic        uop_ready;
  reg_type     bus_input_selector;
  reg_type     bus_output_selector;
  reg_inc_type increment_selector;
  alu_op_type  alu_op;
  logic [7:0]  immed;
  logic [3:0]  a, b, temp_a, temp_b;
  logic [11:0] x, y, pc;
  logic [7:0]  sp;
  logic        zero, carry, decimal, interrupt;

  model_t      expected;
  logic [3:0]  model_mem [0:4095];
  bit          written [0:4095];
  logic [31:0] lfsr_state = 32'h3c50_c0c4;
  logic        checking = 1'b0;
  int          cycles = 0;

  core_top dut (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int draw_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = (v << 1) | lfsr_state[0];
    end
    return v;
  endfunction

  // Bit 4 is carry, or borrow for SUB
  function automatic logic [4:0] alu_ref(input logic [3:0] l, input logic [3:0] r,
                                         input logic cin, input alu_op_type op);
    case (op)
      ALU_ADD: return l + r;
      ALU_ADC: return l + r + cin;
      ALU_SUB: return {r > l, l - r};
      ALU_AND: return {1'b0, l & r};
      ALU_OR:  return {1'b0, l | r};
      ALU_XOR: return {1'b0, l ^ r};
      default: return 5'h00;
    endcase
  endfunction

  function automatic logic [11:0] mem_addr(input model_t s, input reg_type sel,
                                           input logic [7:0] imm);
    case (sel)
      REG_MX:      return s.x;
      REG_MY:      return s.y;
      REG_MSP:     return {4'h0, s.sp};
      REG_MSP_DEC: return {4'h0, s.sp - 8'h01};
      default:     return {8'h00, imm[3:0]};
    endcase
  endfunction

  function automatic logic [3:0] source_nibble(input model_t s, input reg_type sel,
                                               input alu_op_type op, input logic [7:0] imm);
    logic [4:0] r;
    r = alu_ref(s.temp_a, s.temp_b, s.flags[0], op);
    case (sel)
      REG_A:     return s.a;
      REG_B:     return s.b;
      REG_TEMPA: return s.temp_a;
      REG_TEMPB: return s.temp_b;
      REG_XL:    return s.x[3:0];
      REG_XH:    return s.x[7:4];
      REG_XP:    return s.x[11:8];
      REG_YL:    return s.y[3:0];
      REG_YH:    return s.y[7:4];
      REG_YP:    return s.y[11:8];
      REG_SPL:   return s.sp[3:0];
      REG_SPH:   return s.sp[7:4];
      REG_PCSL:  return s.pc[3:0];
      REG_PCSH:  return s.pc[7:4];
      REG_PCP:   return s.pc[11:8];
      REG_FLAGS: return s.flags;
      REG_ALU, REG_ALU_WITH_FLAGS: return r[3:0];
      REG_IMML:  return imm[3:0];
      REG_IMMH:  return imm[7:4];
      default:   return model_mem[mem_addr(s, sel, imm)];
    endcase
  endfunction

  // Reference model: one micro-op through fetch and write
  function automatic model_t next_state(input model_t s, input reg_type src, input reg_type dst,
                                        input reg_inc_type inc, input alu_op_type op,
                                        input logic [7:0] imm);
    model_t     m;
    model_t     n;
    logic [3:0] v;
    logic [3:0] wd;
    logic [4:0] r;
    logic [11:0] wa;
    // Fetch cycle
    wd = source_nibble(s, src, op, imm);
    wa = mem_addr(s, dst, imm);
    m = s;
    if (inc == REG_PC) m.pc = s.pc + 12'h001;
    // Write cycle, all reads from the post-fetch state
    n = m;
    v = source_nibble(m, src, op, imm);
    r = alu_ref(m.temp_a, m.temp_b, m.flags[0], op);
    case (dst)
      REG_A:     n.a = v;
      REG_B:     n.b = v;
      REG_TEMPA: n.temp_a = v;
      REG_TEMPB: n.temp_b = v;
      REG_XL:    n.x[3:0] = v;
      REG_XH:    n.x[7:4] = v;
      REG_XP:    n.x[11:8] = v;
      REG_YL:    n.y[3:0] = v;
      REG_YH:    n.y[7:4] = v;
      REG_YP:    n.y[11:8] = v;
      REG_SPL:   n.sp[3:0] = v;
      REG_SPH:   n.sp[7:4] = v;
      REG_PCSL:  n.pc[3:0] = v;
      REG_PCSH:  n.pc[7:4] = v;
      REG_PCP:   n.pc[11:8] = v;
      REG_FLAGS: n.flags = v;
      default: ;
    endcase
    if (src == REG_ALU_WITH_FLAGS && dst != REG_FLAGS) begin
      n.flags[1] = (r[3:0] == 4'h0);
      n.flags[0] = r[4];
    end
    // Increment overrides the bus write
    case (inc)
      REG_XHL:    n.x[7:0] = m.x[7:0] + 8'h01;
      REG_YHL:    n.y[7:0] = m.y[7:0] + 8'h01;
      REG_SP_INC: n.sp = m.sp + 8'h01;
      REG_SP_DEC: n.sp = m.sp - 8'h01;
      default: ;
    endcase
    if (dst >= REG_MX) begin
      model_mem[wa] = wd;
      written[wa] = 1'b1;
    end
    return n;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] seen,
                               input logic [31:0] want);
    if (seen !== want) begin
      $display("Error at %0t ns: %s seen %h expected %h", $time, name, seen, want);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // Compare whenever the sequencer is idle
  always @(negedge clk) begin
    if (checking && uop_ready) begin
      compare_value("a", a, expected.a);
      compare_value("b", b, expected.b);
      compare_value("temp_a", temp_a, expected.temp_a);
      compare_value("temp_b", temp_b, expected.temp_b);
      compare_value("x", x, expected.x);
      compare_value("y", y, expected.y);
      compare_value("pc", pc, expected.pc);
      compare_value("sp", sp, expected.sp);
      compare_value("interrupt", interrupt, expected.flags[3]);
      compare_value("decimal", decimal, expected.flags[2]);
      compare_value("zero", zero, expected.flags[1]);
      compare_value("carry", carry, expected.flags[0]);
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  initial begin
    reg_type     src;
    reg_type     dst;
    reg_inc_type inc;
    alu_op_type  op;
    logic [7:0]  imm;
    int          dst_v;
    int          busy;
    int          gap;
    reset_n = 1'b0;
    uop_valid = 1'b0;
    bus_input_selector = REG_A;
    bus_output_selector = REG_A;
    increment_selector = REG_NONE;
    alu_op = ALU_ADD;
    immed = 8'h00;
    expected = '0;
    expected.pc = PC_RESET;
    repeat (10) @(negedge clk);
    reset_n = 1'b1;
    // Reset values are compared on the next falling edge
    checking = 1'b1;
    @(negedge clk);
    compare_value("uop_ready", uop_ready, 1);
    for (int n = 0; n < NUM_UOPS; n++) begin
      src = reg_type'(draw_bits(5) % 25);
      dst_v = draw_bits(5) % 21;
      // Skip the source-only selectors
      dst = reg_type'(dst_v >= 16 ? dst_v + 4 : dst_v);
      inc = reg_inc_type'(draw_bits(3) % 6);
      op = alu_op_type'(draw_bits(3) % 6);
      imm = 8'(draw_bits(8));
      // Load only from RAM cells that hold data
      if (src >= REG_MX && !written[mem_addr(expected, src, imm)]) src = REG_IMML;
      bus_input_selector = src;
      bus_output_selector = dst;
      increment_selector = inc;
      alu_op = op;
      immed = imm;
      uop_valid = 1'b1;
      @(negedge clk);
      expected = next_state(expected, src, dst, inc, op, imm);
      busy = 1;
      // Valid stays high while busy
      while (!uop_ready) begin
        @(negedge clk);
        busy++;
      end
      compare_value("accept_to_ready", busy, 3);
      gap = draw_bits(2);
      if (gap != 0) begin
        uop_valid = 1'b0;
        repeat (gap) @(negedge clk);
      end
    end
    uop_valid = 1'b0;
    repeat (2) @(negedge clk);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
hdl/core_pkg.sv
hdl/uop_if.sv
hdl/mem_if.sv
hdl/uop_sequencer.sv
hdl/alu.sv
hdl/reg_mux.sv
hdl/regs.sv
hdl/data_ram.sv
hdl/core_top.sv
verification/core_tb.sv
